// ==== Bender.yml ====
package:
  name: time_link

sources:
  - files:
      - design/time_link_pkg.sv
      - design/encode_8b10b.sv
      - design/decode_8b10b.sv
      - design/time_sender.sv
      - design/time_receiver.sv
      - design/time_link_regs.sv
      - design/time_link_top.sv
  - target: simulation
    files:
      - testbench/time_link_chk.sv
      - testbench/time_link_tb.sv

// ==== design/decode_8b10b.sv ====
module decode_8b10b
(
   input  logic [time_link_pkg::code_w-1:0] code,
   input  logic                             disp_in,
   output logic [time_link_pkg::sym_w-1:0]  data,
   output logic                             disp_out,
   output logic                             code_err,
   output logic                             disp_err
);

   logic [5:0] abcdei;
   logic [3:0] fghj;
   logic [3:0] f4;
   logic [4:0] d5;
   logic [2:0] d3;
   logic       bad6;
   logic       bad4;
   logic       k28;
   logic       a7;
   logic       k_flag;
   logic       rd6;
   int         w6;
   int         w4;

   assign abcdei = {code[0], code[1], code[2], code[3], code[4], code[5]};
   assign fghj   = {code[6], code[7], code[8], code[9]};
   assign k28    = (abcdei == 6'b001111) || (abcdei == 6'b110000);
   // After a positive K28 the whole 3b/4b block is inverted.
   assign f4     = (abcdei == 6'b110000) ? ~fghj : fghj;
   assign a7     = (f4 == 4'b0111) || (f4 == 4'b1000);

   always_comb
   begin
      bad6 = 1'b0;
      case (abcdei)
         6'b100111, 6'b011000: d5 = 5'd0;
         6'b011101, 6'b100010: d5 = 5'd1;
         6'b101101, 6'b010010: d5 = 5'd2;
         6'b110001:            d5 = 5'd3;
         6'b110101, 6'b001010: d5 = 5'd4;
         6'b101001:            d5 = 5'd5;
         6'b011001:            d5 = 5'd6;
         6'b111000, 6'b000111: d5 = 5'd7;
         6'b111001, 6'b000110: d5 = 5'd8;
         6'b100101:            d5 = 5'd9;
         6'b010101:            d5 = 5'd10;
         6'b110100:            d5 = 5'd11;
         6'b001101:            d5 = 5'd12;
         6'b101100:            d5 = 5'd13;
         6'b011100:            d5 = 5'd14;
         6'b010111, 6'b101000: d5 = 5'd15;
         6'b011011, 6'b100100: d5 = 5'd16;
         6'b100011:            d5 = 5'd17;
         6'b010011:            d5 = 5'd18;
         6'b110010:            d5 = 5'd19;
         6'b001011:            d5 = 5'd20;
         6'b101010:            d5 = 5'd21;
         6'b011010:            d5 = 5'd22;
         6'b111010, 6'b000101: d5 = 5'd23;
         6'b110011, 6'b001100: d5 = 5'd24;
         6'b100110:            d5 = 5'd25;
         6'b010110:            d5 = 5'd26;
         6'b110110, 6'b001001: d5 = 5'd27;
         6'b001110, 6'b001111: d5 = 5'd28;
         6'b110000:            d5 = 5'd28;
         6'b101110, 6'b010001: d5 = 5'd29;
         6'b011110, 6'b100001: d5 = 5'd30;
         6'b101011, 6'b010100: d5 = 5'd31;
         default:
         begin
            d5 = 5'd0;
            bad6 = 1'b1;
         end
      endcase
   end

   always_comb
   begin
      bad4 = 1'b0;
      case (f4)
         4'b1011, 4'b0100:                   d3 = 3'd0;
         4'b1001:                            d3 = 3'd1;
         4'b0101:                            d3 = 3'd2;
         4'b1100, 4'b0011:                   d3 = 3'd3;
         4'b1101, 4'b0010:                   d3 = 3'd4;
         4'b1010:                            d3 = 3'd5;
         4'b0110:                            d3 = 3'd6;
         4'b1110, 4'b0001, 4'b0111, 4'b1000: d3 = 3'd7;
         default:
         begin
            d3 = 3'd0;
            bad4 = 1'b1;
         end
      endcase
   end

   // The alternate x.7 form marks a control code only after these four blocks.
   assign k_flag = k28 || (a7 && (d5 == 5'd23 || d5 == 5'd27 || d5 == 5'd29 || d5 == 5'd30));

   assign w6       = $countones(abcdei);
   assign w4       = $countones(fghj);
   assign rd6      = (w6 == 3) ? disp_in : (w6 > 3);
   assign disp_out = (w4 == 2) ? rd6 : (w4 > 2);
   assign disp_err = (disp_in && w6 > 3) || (!disp_in && w6 < 3) ||
                     (rd6 && w4 > 2) || (!rd6 && w4 < 2) ||
                     (abcdei == 6'b111000 && disp_in) || (abcdei == 6'b000111 && !disp_in) ||
                     (fghj == 4'b1100 && rd6) || (fghj == 4'b0011 && !rd6);

   assign data     = {k_flag, d3, d5};
   assign code_err = bad6 | bad4;

endmodule

// ==== design/encode_8b10b.sv ====
module encode_8b10b
(
   input  logic [time_link_pkg::sym_w-1:0]  data,
   input  logic                             disp_in,
   output logic [time_link_pkg::code_w-1:0] code,
   output logic                             disp_out
);

   logic [5:0] t6;
   logic [3:0] t4;
   logic [5:0] abcdei;
   logic [3:0] fghj;
   logic       k28;
   logic       rd6;
   logic       use_a7;
   logic       comp4;
   int         w6;
   int         w4;

   assign k28 = data[8] && (data[4:0] == 5'd28);

   // Table literals are written with bit a on the left, as in the usual tables.
   always_comb
   begin
      case (data[4:0])
         5'd0:    t6 = 6'b100111;
         5'd1:    t6 = 6'b011101;
         5'd2:    t6 = 6'b101101;
         5'd3:    t6 = 6'b110001;
         5'd4:    t6 = 6'b110101;
         5'd5:    t6 = 6'b101001;
         5'd6:    t6 = 6'b011001;
         5'd7:    t6 = 6'b111000;
         5'd8:    t6 = 6'b111001;
         5'd9:    t6 = 6'b100101;
         5'd10:   t6 = 6'b010101;
         5'd11:   t6 = 6'b110100;
         5'd12:   t6 = 6'b001101;
         5'd13:   t6 = 6'b101100;
         5'd14:   t6 = 6'b011100;
         5'd15:   t6 = 6'b010111;
         5'd16:   t6 = 6'b011011;
         5'd17:   t6 = 6'b100011;
         5'd18:   t6 = 6'b010011;
         5'd19:   t6 = 6'b110010;
         5'd20:   t6 = 6'b001011;
         5'd21:   t6 = 6'b101010;
         5'd22:   t6 = 6'b011010;
         5'd23:   t6 = 6'b111010;
         5'd24:   t6 = 6'b110011;
         5'd25:   t6 = 6'b100110;
         5'd26:   t6 = 6'b010110;
         5'd27:   t6 = 6'b110110;
         5'd28:   t6 = k28 ? 6'b001111 : 6'b001110;
         5'd29:   t6 = 6'b101110;
         5'd30:   t6 = 6'b011110;
         default: t6 = 6'b101011;
      endcase
      w6 = $countones(t6);
      // Unbalanced blocks and D.07 take the complement under positive disparity.
      abcdei = (disp_in && (w6 != 3 || t6 == 6'b111000)) ? ~t6 : t6;
      rd6 = (w6 == 3) ? disp_in : ~disp_in;

      use_a7 = data[8] ||
               (!rd6 && (data[4:0] == 5'd17 || data[4:0] == 5'd18 || data[4:0] == 5'd20)) ||
               (rd6 && (data[4:0] == 5'd11 || data[4:0] == 5'd13 || data[4:0] == 5'd14));
      case (data[7:5])
         3'd0:    t4 = 4'b1011;
         3'd1:    t4 = 4'b1001;
         3'd2:    t4 = 4'b0101;
         3'd3:    t4 = 4'b1100;
         3'd4:    t4 = 4'b1101;
         3'd5:    t4 = 4'b1010;
         3'd6:    t4 = 4'b0110;
         default: t4 = use_a7 ? 4'b0111 : 4'b1110;
      endcase
      w4 = $countones(t4);
      // K28 flips its balanced 3b/4b codes the other way round.
      if (w4 != 2 || t4 == 4'b1100)
         comp4 = rd6;
      else
         comp4 = k28 && !rd6;
      fghj = comp4 ? ~t4 : t4;
      disp_out = (w4 == 2) ? rd6 : ~rd6;

      code = {fghj[0], fghj[1], fghj[2], fghj[3],
              abcdei[0], abcdei[1], abcdei[2], abcdei[3], abcdei[4], abcdei[5]};
   end

endmodule

// ==== design/time_link_pkg.sv ====
package time_link_pkg;

   // ***********************************************************
   // Link widths
   // ***********************************************************
   localparam int sym_w      = 9;
   localparam int code_w     = 10;
   localparam int time_w     = 64;
   localparam int time_bytes = 8;

   // ***********************************************************
   // Line symbols
   // ***********************************************************
   // K28.5 as it sits in a 10-bit word, bit a in bit 0.
   localparam logic [9:0] k_comma_rd_neg = 10'h17C;
   localparam logic [9:0] k_comma_rd_pos = 10'h283;

   // Symbols are a control flag above a byte.
   localparam logic [8:0] sym_comma = 9'h1BC;
   localparam logic [8:0] sym_head  = 9'h13C;
   localparam logic [8:0] sym_tail  = 9'h1F7;

   // ***********************************************************
   // APB register offsets
   // ***********************************************************
   localparam logic [4:0] reg_tx_lo  = 5'h00;
   localparam logic [4:0] reg_tx_hi  = 5'h04;
   localparam logic [4:0] reg_ctrl   = 5'h08;
   localparam logic [4:0] reg_rx_lo  = 5'h0C;
   localparam logic [4:0] reg_rx_hi  = 5'h10;
   localparam logic [4:0] reg_status = 5'h14;

endpackage

// ==== design/time_link_regs.sv ====
module time_link_regs #(
   parameter int ADDR_W = 8
)
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             psel,
   input  logic                             penable,
   input  logic                             pwrite,
   input  logic [ADDR_W-1:0]                paddr,
   input  logic [31:0]                      pwdata,
   output logic [31:0]                      prdata,
   output logic                             pready,
   output logic                             pslverr,
   output logic [time_link_pkg::time_w-1:0] tx_time,
   output logic                             send,
   input  logic                             tx_busy,
   input  logic [time_link_pkg::time_w-1:0] rx_time,
   input  logic                             sync_rcvd,
   input  logic                             sym_err
);

   import time_link_pkg::*;

   logic [time_w-1:0] rx_snap;
   logic [7:0]        frame_cnt;
   logic [4:0]        offset;
   logic              rx_error;
   logic              off_ok;
   logic              mapped;
   logic              read_only;
   logic              wr_en;
   logic              ctrl_wr;

   assign offset = paddr[4:0];
   assign off_ok = ((paddr >> 5) == '0);

   // ***********************************************************
   // Address decode and read mux
   // ***********************************************************
   always_comb
   begin
      mapped    = off_ok;
      read_only = 1'b0;
      prdata    = '0;
      case (offset)
         reg_tx_lo:  prdata = tx_time[31:0];
         reg_tx_hi:  prdata = tx_time[63:32];
         reg_ctrl:   prdata = '0;
         reg_rx_lo:
         begin
            prdata    = rx_snap[31:0];
            read_only = 1'b1;
         end
         reg_rx_hi:
         begin
            prdata    = rx_snap[63:32];
            read_only = 1'b1;
         end
         reg_status:
         begin
            prdata    = {16'h0, frame_cnt, 6'h0, rx_error, tx_busy};
            read_only = 1'b1;
         end
         default:    mapped = 1'b0;
      endcase
   end

   assign pready  = 1'b1;
   assign pslverr = psel && penable && (!mapped || (pwrite && read_only));
   assign wr_en   = psel && penable && pwrite && mapped && !read_only;
   assign ctrl_wr = wr_en && (offset == reg_ctrl);

   always_ff @(posedge clk)
   begin
      if (wr_en && offset == reg_tx_lo)
         tx_time[31:0] <= pwdata;
      if (wr_en && offset == reg_tx_hi)
         tx_time[63:32] <= pwdata;
   end

   // ***********************************************************
   // Control, receive snapshot and status
   // ***********************************************************
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         send      <= 1'b0;
         rx_error  <= 1'b0;
         frame_cnt <= '0;
         rx_snap   <= '0;
      end
      else
      begin
         send <= ctrl_wr && pwdata[0];
         // A new error wins over a clear in the same cycle.
         if (sym_err)
            rx_error <= 1'b1;
         else if (ctrl_wr && pwdata[1])
            rx_error <= 1'b0;
         if (sync_rcvd)
         begin
            rx_snap   <= rx_time;
            frame_cnt <= frame_cnt + 8'd1;
         end
      end
   end

endmodule

// ==== design/time_link_top.sv ====
module time_link_top #(
   parameter int ADDR_W = 8
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   input  logic              exp_time_in,
   output logic              exp_time_out
);

   import time_link_pkg::*;

   logic [time_w-1:0] tx_time;
   logic [time_w-1:0] rx_time;
   logic              send;
   logic              tx_busy;
   logic              sync_rcvd;
   logic              sym_err;

   time_link_regs #(
      .ADDR_W (ADDR_W)
   ) u_regs
   (
      .clk       (clk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .tx_time   (tx_time),
      .send      (send),
      .tx_busy   (tx_busy),
      .rx_time   (rx_time),
      .sync_rcvd (sync_rcvd),
      .sym_err   (sym_err)
   );

   time_sender u_sender
   (
      .clk          (clk),
      .rst          (rst),
      .send         (send),
      .tx_time      (tx_time),
      .tx_busy      (tx_busy),
      .exp_time_out (exp_time_out)
   );

   time_receiver u_receiver
   (
      .clk         (clk),
      .rst         (rst),
      .exp_time_in (exp_time_in),
      .rx_time     (rx_time),
      .sync_rcvd   (sync_rcvd),
      .sym_err     (sym_err)
   );

endmodule

// ==== design/time_receiver.sv ====
module time_receiver
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             exp_time_in,
   output logic [time_link_pkg::time_w-1:0] rx_time,
   output logic                             sync_rcvd,
   output logic                             sym_err
);

   import time_link_pkg::*;

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_data = 2'd1;
   localparam logic [1:0] st_tail = 2'd2;

   logic [code_w-1:0] shift_reg;
   logic [sym_w-1:0]  dec_data;
   logic [sym_w-1:0]  sym_reg;
   logic [3:0]        bit_cnt;
   logic [2:0]        byte_cnt;
   logic [1:0]        state;
   logic              locked;
   logic              disp;
   logic              dec_disp;
   logic              code_err;
   logic              disp_err;
   logic              found_comma;
   logic              word_done;
   logic              sym_vld;
   logic              sym_bad;

   // ***********************************************************
   // Word alignment
   // ***********************************************************
   always_ff @(posedge clk)
      shift_reg <= {exp_time_in, shift_reg[code_w-1:1]};

   assign found_comma = (shift_reg == k_comma_rd_neg) || (shift_reg == k_comma_rd_pos);
   // Commas only align the word clock, so they never reach the frame FSM.
   assign word_done   = locked && (bit_cnt == 4'd9) && !found_comma;

   decode_8b10b u_decode
   (
      .code     (shift_reg),
      .disp_in  (disp),
      .data     (dec_data),
      .disp_out (dec_disp),
      .code_err (code_err),
      .disp_err (disp_err)
   );

   always_ff @(posedge clk)
   begin
      if (found_comma)
         disp <= (shift_reg == k_comma_rd_neg);
      else if (word_done)
         disp <= dec_disp;
      if (word_done)
      begin
         sym_reg <= dec_data;
         sym_bad <= code_err | disp_err;
      end
   end

   // ***********************************************************
   // Frame FSM
   // ***********************************************************
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bit_cnt  <= '0;
         locked   <= 1'b0;
         sym_vld  <= 1'b0;
         state    <= st_idle;
         byte_cnt <= '0;
      end
      else
      begin
         sym_vld <= word_done;
         if (found_comma)
         begin
            bit_cnt <= '0;
            locked  <= 1'b1;
         end
         else
            bit_cnt <= (bit_cnt == 4'd9) ? 4'd0 : bit_cnt + 4'd1;

         if (sym_vld)
         begin
            if (sym_bad)
               state <= st_idle;
            else
               case (state)
                  st_idle:
                     if (sym_reg == sym_head)
                     begin
                        state    <= st_data;
                        byte_cnt <= '0;
                     end
                  st_data:
                     if (sym_reg[8])
                        state <= st_idle;
                     else
                     begin
                        if (byte_cnt == 3'(time_bytes - 1))
                           state <= st_tail;
                        byte_cnt <= byte_cnt + 3'd1;
                     end
                  default:
                     state <= st_idle;
               endcase
         end
      end
   end

   always_ff @(posedge clk)
      if (sym_vld && !sym_bad && state == st_data && !sym_reg[8])
         rx_time[8 * (time_bytes - 1 - int'(byte_cnt)) +: 8] <= sym_reg[7:0];

   assign sym_err   = sym_vld && sym_bad;
   assign sync_rcvd = sym_vld && !sym_bad && (state == st_tail) && (sym_reg == sym_tail);

endmodule

// ==== design/time_sender.sv ====
module time_sender
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             send,
   input  logic [time_link_pkg::time_w-1:0] tx_time,
   output logic                             tx_busy,
   output logic                             exp_time_out
);

   import time_link_pkg::*;

   // Symbol index 0 is the leading comma, 1 is HEAD, then the bytes, then TAIL.
   localparam logic [3:0] idx_tail = 4'(time_bytes + 2);
   localparam logic [3:0] idx_end  = 4'(time_bytes + 3);

   logic [time_w-1:0] frame_time;
   logic [code_w-1:0] shift_reg;
   logic [code_w-1:0] code;
   logic [sym_w-1:0]  sym;
   logic [3:0]        bit_cnt;
   logic [3:0]        sym_idx;
   logic              disp;
   logic              disp_next;
   logic              load;
   logic              is_data;

   assign load    = (bit_cnt == 4'd9);
   assign is_data = tx_busy && (sym_idx >= 4'd2) && (sym_idx < idx_tail);

   always_comb
   begin
      if (!tx_busy || sym_idx == 4'd0)
         sym = sym_comma;
      else if (sym_idx == 4'd1)
         sym = sym_head;
      else if (is_data)
         sym = {1'b0, frame_time[time_w-1 -: 8]};
      else if (sym_idx == idx_tail)
         sym = sym_tail;
      else
         sym = sym_comma;
   end

   encode_8b10b u_encode
   (
      .data     (sym),
      .disp_in  (disp),
      .code     (code),
      .disp_out (disp_next)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bit_cnt <= 4'd9;
         sym_idx <= '0;
         tx_busy <= 1'b0;
         disp    <= 1'b0;
      end
      else
      begin
         bit_cnt <= load ? 4'd0 : bit_cnt + 4'd1;
         if (load)
            disp <= disp_next;
         if (load && tx_busy)
         begin
            // The boundary after TAIL has sent its last bit ends the frame.
            if (sym_idx == idx_end)
            begin
               sym_idx <= '0;
               tx_busy <= 1'b0;
            end
            else
               sym_idx <= sym_idx + 4'd1;
         end
         else if (send)
            tx_busy <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (send && !tx_busy)
         frame_time <= tx_time;
      else if (load && is_data)
         frame_time <= frame_time << 8;
      shift_reg <= load ? code : {1'b0, shift_reg[code_w-1:1]};
   end

   assign exp_time_out = shift_reg[0];

endmodule

// ==== files.f ====
design/time_link_pkg.sv
design/encode_8b10b.sv
design/decode_8b10b.sv
design/time_sender.sv
design/time_receiver.sv
design/time_link_regs.sv
design/time_link_top.sv
testbench/time_link_chk.sv
testbench/time_link_tb.sv

// ==== testbench/time_link_chk.sv ====
module time_link_chk
(
   input logic clk,
   input logic rst,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic pslverr,
   input logic send,
   input logic sync_rcvd,
   input logic sym_err
);

   timeunit 1ns;
   timeprecision 1ps;

   // Number of assertion failures, read by the testbench at the end of the run.
   int fail_cnt = 0;

   a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
      else
      begin
         $error("pready dropped to 0");
         fail_cnt++;
      end

   a_pslverr_access: assert property (@(posedge clk) disable iff (rst)
                                      pslverr |-> (psel && penable))
      else
      begin
         $error("pslverr high outside the access phase");
         fail_cnt++;
      end

   a_sync_vs_err: assert property (@(posedge clk) disable iff (rst) !(sync_rcvd && sym_err))
      else
      begin
         $error("sync_rcvd and sym_err high in the same cycle");
         fail_cnt++;
      end

   a_send_pulse: assert property (@(posedge clk) disable iff (rst) send |=> !send)
      else
      begin
         $error("send stayed high for more than one cycle");
         fail_cnt++;
      end

endmodule

// ==== testbench/time_link_tb.sv ====
module time_link_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import time_link_pkg::*;

   localparam int addr_w        = 8;
   localparam int clk_ns        = 40;
   localparam int n_round       = 20;
   localparam int n_frames      = n_round + 6;
   localparam int frame_cycles  = 140;
   localparam int margin_cycles = 4000;
   localparam int poll_limit    = 100;
   localparam int sample_ns     = 5;
   localparam int rx_settle     = 40;

   logic              clk = 1'b0;
   logic              rst;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [addr_w-1:0] paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   logic              exp_time_in;
   logic              exp_time_out;
   logic              flip_bit = 1'b0;

   // Reference model of the link as seen from software.
   logic [63:0] model_tx = '0;
   logic [63:0] model_rx = '0;
   logic [7:0]  model_count = '0;
   logic        model_err = 1'b0;

   logic [31:0] rng_state = 32'd59;
   int          errors = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          errors_at_start = 0;

   // Line monitor state for bit error injection.
   logic [9:0]  line_sr;
   int          line_pos = 0;
   logic        inject_armed = 1'b0;
   logic        head_seen = 1'b0;
   logic        injected = 1'b0;
   int          inject_delay = 0;
   int          inject_cnt = 0;

   always #(clk_ns / 2) clk = ~clk;

   assign exp_time_in = exp_time_out ^ flip_bit;

   time_link_top #(
      .ADDR_W (addr_w)
   ) u_time_link_top
   (
      .clk          (clk),
      .rst          (rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .exp_time_in  (exp_time_in),
      .exp_time_out (exp_time_out)
   );

   bind time_link_regs time_link_chk u_chk (.*);

   // ***********************************************************
   // Random numbers and checks
   // ***********************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [63:0] rand64();
      logic [31:0] hi;
      hi = rand32();
      return {hi, rand32()};
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %s: ok", name);
      else
      begin
         $display("test %s: failed with %0d errors", name, errors - errors_at_start);
         tests_failed++;
      end
      errors_at_start = errors;
   endtask

   // ***********************************************************
   // APB master
   // ***********************************************************
   task automatic apb_access(input logic [addr_w-1:0] addr, input logic write,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #(sample_ns);
      rdata = prdata;
      err   = pslverr;
      check("pready", pready, 1'b1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused;
      apb_access(addr, 1'b1, data, unused, err);
   endtask

   task automatic apb_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
                           output logic err);
      apb_access(addr, 1'b0, '0, data, err);
   endtask

   task automatic write_ok(input logic [addr_w-1:0] addr, input logic [31:0] data);
      logic err;
      apb_write(addr, data, err);
      check("pslverr", err, 1'b0);
   endtask

   task automatic read_check(input logic [addr_w-1:0] addr, input string name,
                             input logic [31:0] exp);
      logic [31:0] data;
      logic        err;
      apb_read(addr, data, err);
      check(name, data, exp);
      check("pslverr", err, 1'b0);
   endtask

   function automatic logic [31:0] exp_status(input logic busy);
      return {16'h0, model_count, 6'h0, model_err, busy};
   endfunction

   // ***********************************************************
   // Link helpers
   // ***********************************************************
   task automatic send_time(input logic [63:0] t);
      write_ok(reg_tx_lo, t[31:0]);
      write_ok(reg_tx_hi, t[63:32]);
      model_tx = t;
      write_ok(reg_ctrl, 32'h1);
   endtask

   task automatic wait_frame(output logic [31:0] status);
      int   polls;
      logic err;
      polls = 0;
      apb_read(reg_status, status, err);
      while (status[15:8] == model_count && polls < poll_limit)
      begin
         apb_read(reg_status, status, err);
         polls++;
      end
      if (status[15:8] == model_count)
      begin
         $display("no frame was received within %0d status polls", poll_limit);
         errors++;
      end
   endtask

   task automatic wait_idle();
      logic [31:0] status;
      logic        err;
      int          polls;
      polls = 0;
      apb_read(reg_status, status, err);
      while (status[0] && polls < poll_limit)
      begin
         apb_read(reg_status, status, err);
         polls++;
      end
      if (status[0])
      begin
         $display("the sender stayed busy for %0d status polls", poll_limit);
         errors++;
      end
   endtask

   task automatic round_trip(input logic [63:0] t);
      logic [31:0] status;
      send_time(t);
      wait_frame(status);
      model_count = model_count + 8'd1;
      model_rx    = t;
      check("status", status, exp_status(1'b0));
      read_check(reg_rx_lo, "rx_lo", model_rx[31:0]);
      read_check(reg_rx_hi, "rx_hi", model_rx[63:32]);
   endtask

   // Follows word alignment on the line and flips one bit after HEAD when armed.
   always @(negedge clk)
   begin
      flip_bit = 1'b0;
      line_sr  = {exp_time_out, line_sr[9:1]};
      if (head_seen)
      begin
         if (inject_cnt == inject_delay)
         begin
            flip_bit  = 1'b1;
            injected  = 1'b1;
            head_seen = 1'b0;
         end
         inject_cnt++;
      end
      if (line_sr == k_comma_rd_neg || line_sr == k_comma_rd_pos)
         line_pos = 0;
      else
      begin
         line_pos++;
         // The first word that is not a comma is the frame's HEAD.
         if (line_pos == 10)
         begin
            line_pos = 0;
            if (inject_armed)
            begin
               head_seen    = 1'b1;
               inject_cnt   = 0;
               inject_armed = 1'b0;
            end
         end
      end
   end

   initial
   begin
      #(n_frames * frame_cycles * clk_ns + margin_cycles * clk_ns);
      $display("watchdog expired before the tests finished");
      $display("TB FAILED");
      $finish;
   end

   // ***********************************************************
   // Test sequence
   // ***********************************************************
   initial
   begin
      logic [63:0] t;
      logic [63:0] t2;
      logic [31:0] status;
      logic [31:0] data;
      logic        err;
      int          asrt_fails;

      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      read_check(reg_status, "status", 32'h0);
      read_check(reg_rx_lo, "rx_lo", 32'h0);
      read_check(reg_rx_hi, "rx_hi", 32'h0);
      finish_test("reset_values");

      for (int i = 0; i < n_round; i++)
         round_trip(rand64());
      finish_test("round_trip");

      // The second send lands while the first frame is on the line.
      t  = rand64();
      t2 = rand64();
      send_time(t);
      read_check(reg_status, "status", exp_status(1'b1));
      send_time(t2);
      wait_frame(status);
      model_count = model_count + 8'd1;
      model_rx    = t;
      check("status", status, exp_status(1'b0));
      repeat (frame_cycles) @(negedge clk);
      read_check(reg_status, "status", exp_status(1'b0));
      read_check(reg_rx_lo, "rx_lo", model_rx[31:0]);
      read_check(reg_rx_hi, "rx_hi", model_rx[63:32]);
      finish_test("busy_frames");

      // One of the first four data bytes is hit, so TAIL still sees the damage.
      inject_delay = 10 * int'(rand32() % 4) + int'(rand32() % 10);
      injected     = 1'b0;
      inject_armed = 1'b1;
      send_time(rand64());
      wait_idle();
      repeat (rx_settle) @(negedge clk);
      if (!injected)
      begin
         $display("the bit error was never injected into the frame");
         errors++;
      end
      model_err = 1'b1;
      read_check(reg_status, "status", exp_status(1'b0));
      read_check(reg_rx_lo, "rx_lo", model_rx[31:0]);
      read_check(reg_rx_hi, "rx_hi", model_rx[63:32]);
      write_ok(reg_ctrl, 32'h2);
      model_err = 1'b0;
      read_check(reg_status, "status", exp_status(1'b0));
      round_trip(rand64());
      finish_test("error_injection");

      apb_read(8'h18, data, err);
      check("pslverr", err, 1'b1);
      apb_write(8'h20, rand32(), err);
      check("pslverr", err, 1'b1);
      apb_write(reg_status, 32'hFFFF_FFFF, err);
      check("pslverr", err, 1'b1);
      apb_write(reg_rx_lo, rand32(), err);
      check("pslverr", err, 1'b1);
      read_check(reg_tx_lo, "tx_lo", model_tx[31:0]);
      read_check(reg_tx_hi, "tx_hi", model_tx[63:32]);
      read_check(reg_rx_lo, "rx_lo", model_rx[31:0]);
      read_check(reg_status, "status", exp_status(1'b0));
      finish_test("bad_accesses");

      asrt_fails = u_time_link_top.u_regs.u_chk.fail_cnt;
      $display("tests %0d, tests failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, checks, errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule
